// ==== common/rx_consts.svh ====
`ifndef RX_CONSTS_SVH
`define RX_CONSTS_SVH

// Packet buffer size in bytes
`define RX_BUF_BYTES 32768

// Byte address width toward buffer memory
`define RX_ADDR_BITS 16

// Longest AXI burst in dwords, bounds frame length to 1024 bytes
`define RX_MAX_BEATS 256

`endif

// ==== common/rx_pkg.sv ====
`include "rx_consts.svh"

package rx_pkg;

	// AXI write address payload
	typedef struct packed {
		logic [`RX_ADDR_BITS-1:0] addr;
		logic [$clog2(`RX_MAX_BEATS)-1:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_aw_t;

	// AXI write data payload
	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	// One frame for the write DMA
	typedef struct packed {
		logic [`RX_ADDR_BITS-1:0] addr;
		logic [15:0] bytes;
	} dma_cmd_t;

	// Report beat 0
	typedef struct packed {
		logic [15:0] len;
		logic [15:0] addr;
	} rpt_place_t;

	// Report beat 1
	typedef struct packed {
		logic [15:0] csum;
		logic [15:0] len;
	} rpt_csum_t;

	// Report beat 2, descriptor flags
	typedef struct packed {
		logic [28:0] rsvd_hi;
		logic ixsm;
		logic [1:0] rsvd_lo;
	} rpt_desc_t;

	typedef union packed {
		rpt_place_t place;
		rpt_csum_t csum;
		rpt_desc_t desc;
	} rpt_word_u;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_rx_frame -f tb.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q '^TB PASSED$' &&
echo "simulation passed" ||
{ echo "simulation did not pass"; exit 1; }

// ==== rx_wdma/rx_wdma.sv ====
module rx_wdma import rx_pkg::*; (
	input logic aclk,
	input logic aresetn,

	input dma_cmd_t dma_cmd,
	input logic cmd_valid,
	output logic cmd_ready,

	input logic [31:0] mac_tdata,
	input logic [3:0] mac_tkeep,
	input logic mac_tvalid,
	input logic mac_tlast,
	output logic mac_tready,
	output logic beat_fire,

	output axi_aw_t aw,
	output logic awvalid,
	input logic awready,

	output axi_w_t w,
	output logic wvalid,
	input logic wready,

	input axi_b_t b,
	input logic bvalid,
	output logic bready,

	output logic done,
	output logic [1:0] bresp
);

typedef enum logic [1:0] {
	S_IDLE,
	S_ADDR,
	S_DATA,
	S_RESP
} state_t;

state_t state, state_next;

logic [15:0] dwords;
logic [15:0] beats_m1;

// Round up to whole dwords
assign dwords = (dma_cmd.bytes + 16'd3) >> 2;
assign beats_m1 = dwords - 16'd1;

assign cmd_ready = (state == S_IDLE);
assign awvalid = (state == S_ADDR);
assign bready = 1'b1;

// Stream and AXI stall each other during the burst
assign wvalid = (state == S_DATA) && mac_tvalid;
assign mac_tready = (state == S_DATA) && wready;
assign beat_fire = mac_tvalid && mac_tready;

// Big-endian stream to little-endian memory
assign w.data = {mac_tdata[7:0], mac_tdata[15:8], mac_tdata[23:16], mac_tdata[31:24]};
assign w.strb = {mac_tkeep[0], mac_tkeep[1], mac_tkeep[2], mac_tkeep[3]};
assign w.last = mac_tlast;

always_comb begin
	state_next = state;
	case (state)
		S_IDLE: begin
			if (cmd_valid)
				state_next = S_ADDR;
		end
		S_ADDR: begin
			if (awready)
				state_next = S_DATA;
		end
		S_DATA: begin
			if (beat_fire && mac_tlast)
				state_next = S_RESP;
		end
		S_RESP: begin
			if (bvalid)
				state_next = S_IDLE;
		end
		default: begin
			state_next = S_IDLE;
		end
	endcase
end

always_ff @(posedge aclk or negedge aresetn) begin
	if (!aresetn) begin
		state <= S_IDLE;
		done <= 1'b0;
	end else begin
		state <= state_next;
		done <= (state == S_RESP) && bvalid;
	end
end

// Burst parameters held for the whole transfer
always_ff @(posedge aclk) begin
	if (cmd_valid && cmd_ready) begin
		aw.addr <= dma_cmd.addr;
		aw.len <= beats_m1[$bits(aw.len)-1:0];
		aw.size <= 3'b010;
		aw.burst <= 2'b01;
	end
end

always_ff @(posedge aclk) begin
	if (state == S_RESP && bvalid)
		bresp <= b.resp;
end

endmodule

// ==== tb.f ====
+incdir+common
common/rx_pkg.sv
rx_wdma/rx_wdma.sv
verilog/rx_checksum.sv
verilog/rx_frame_ctrl.sv
verilog/rx_frame.sv
test/tb_rx_mem.sv
test/tb_rx_frame.sv

// ==== test/tb_rx_frame.sv ====
`include "rx_consts.svh"

module tb_rx_frame import rx_pkg::*; ();

localparam int MAX_FRAMES = 128;
localparam int BUF = `RX_BUF_BYTES;
localparam logic [31:0] SEED = 32'h82208dd8;

logic aclk;
logic aresetn;
logic [7:0] pcss;
logic [31:0] mac_tdata;
logic [3:0] mac_tkeep;
logic [15:0] mac_tuser;
logic mac_tvalid;
logic mac_tlast;
logic mac_tready;
logic [31:0] cmd_tdata;
logic cmd_tvalid;
logic cmd_tlast;
logic cmd_tready;
rpt_word_u stat_tdata;
logic stat_tvalid;
logic stat_tlast;
logic stat_tready;
axi_aw_t aw;
logic awvalid;
logic awready;
axi_w_t w;
logic wvalid;
logic wready;
axi_b_t b;
logic bvalid;
logic bready;
logic [`RX_ADDR_BITS:0] ram_available;

logic [7:0] frame_data [MAX_FRAMES][1024];
int frame_len [MAX_FRAMES];
int frame_addr [MAX_FRAMES];
logic [15:0] frame_csum [MAX_FRAMES];
int frames_sent;
int reports_done;
int aw_seen;
int rpt_beat;
int mismatch_errors;
int other_errors;
int next_addr;
int free_space;
int ret_ptr;
logic [31:0] rnd;
logic [31:0] ready_rnd;
bit timed_out;
string timeout_msg;

rx_frame i_dut (
	.aclk(aclk),
	.aresetn(aresetn),
	.pcss(pcss),
	.mac_tdata(mac_tdata),
	.mac_tkeep(mac_tkeep),
	.mac_tuser(mac_tuser),
	.mac_tvalid(mac_tvalid),
	.mac_tlast(mac_tlast),
	.mac_tready(mac_tready),
	.cmd_tdata(cmd_tdata),
	.cmd_tvalid(cmd_tvalid),
	.cmd_tlast(cmd_tlast),
	.cmd_tready(cmd_tready),
	.stat_tdata(stat_tdata),
	.stat_tvalid(stat_tvalid),
	.stat_tlast(stat_tlast),
	.stat_tready(stat_tready),
	.aw(aw),
	.awvalid(awvalid),
	.awready(awready),
	.w(w),
	.wvalid(wvalid),
	.wready(wready),
	.b(b),
	.bvalid(bvalid),
	.bready(bready),
	.ram_available(ram_available)
);

tb_rx_mem #(.SEED(SEED ^ 32'h3c3c1234)) i_mem (
	.aclk(aclk),
	.aresetn(aresetn),
	.aw(aw),
	.awvalid(awvalid),
	.awready(awready),
	.w(w),
	.wvalid(wvalid),
	.wready(wready),
	.b(b),
	.bvalid(bvalid),
	.bready(bready)
);

initial begin
	aclk = 1'b0;
	forever #4 aclk = ~aclk;
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic int round_up(input int len);
	return (len + 3) / 4 * 4;
endfunction

// Even offsets are the high byte of a big-endian 16-bit word
function automatic logic [15:0] ref_checksum(input int f, input int start);
	logic [31:0] acc;
	acc = 32'd0;
	for (int k = start; k < frame_len[f]; k++) begin
		if (k % 2 == 0)
			acc = acc + {16'd0, frame_data[f][k], 8'd0};
		else
			acc = acc + {24'd0, frame_data[f][k]};
	end
	while (acc > 32'h0000ffff)
		acc = (acc & 32'h0000ffff) + (acc >> 16);
	return acc[15:0];
endfunction

function automatic rpt_word_u predict_report(input int f, input int beat);
	rpt_word_u r;
	r = '0;
	if (beat == 0)
		r = {16'(frame_len[f]), 16'(frame_addr[f])};
	else if (beat == 1)
		r = {frame_csum[f], 16'(frame_len[f])};
	else
		r = 32'h0000_0004;
	return r;
endfunction

function automatic axi_aw_t predict_aw(input int f);
	axi_aw_t a;
	a.addr = 16'(frame_addr[f]);
	a.len = 8'(round_up(frame_len[f]) / 4 - 1);
	a.size = 3'b010;
	a.burst = 2'b01;
	return a;
endfunction

task automatic check_rpt(input string name, input rpt_word_u got, input rpt_word_u exp);
	if (got !== exp) begin
		$display("MISMATCH %s got=%h exp=%h", name, got, exp);
		mismatch_errors++;
	end
endtask

task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
	if (got !== exp) begin
		$display("MISMATCH aw got=%h exp=%h", got, exp);
		mismatch_errors++;
	end
endtask

task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp) begin
		$display("MISMATCH %s got=%h exp=%h", name, got, exp);
		mismatch_errors++;
	end
endtask

task automatic check_level(input logic [`RX_ADDR_BITS:0] got, input int exp);
	if (got !== (`RX_ADDR_BITS+1)'(exp)) begin
		$display("MISMATCH ram_available got=%h exp=%h", got, exp);
		mismatch_errors++;
	end
endtask

task automatic raise_timeout(input string why);
	timeout_msg = why;
	timed_out = 1'b1;
endtask

// Ends the run as soon as any wait gives up
initial begin
	while (!timed_out)
		@(timed_out);
	$display("ERROR: %s", timeout_msg);
	$display("TB FAILED");
	$finish;
end

task automatic check_frame_memory(input int f);
	int a;
	for (int k = 0; k < frame_len[f]; k++) begin
		a = (frame_addr[f] + k) % BUF;
		check_byte($sformatf("mem[%0h]", a), i_mem.mem[a], frame_data[f][k]);
	end
endtask

// Report beats in order, memory checked once the last beat is taken
always @(posedge aclk) begin
	if (aresetn && stat_tvalid && stat_tready) begin
		if (reports_done >= frames_sent) begin
			$display("ERROR: report beat arrived with no frame pending");
			other_errors++;
		end else begin
			check_rpt($sformatf("stat_tdata beat %0d", rpt_beat), stat_tdata,
				predict_report(reports_done, rpt_beat));
			if (stat_tlast !== (rpt_beat == 2)) begin
				$display("MISMATCH stat_tlast got=%h exp=%h", stat_tlast, rpt_beat == 2);
				mismatch_errors++;
			end
			if (rpt_beat == 2) begin
				check_frame_memory(reports_done);
				reports_done++;
				rpt_beat = 0;
			end else begin
				rpt_beat++;
			end
		end
	end
end

always @(posedge aclk) begin
	if (aresetn && awvalid && awready) begin
		check_aw(aw, predict_aw(aw_seen));
		aw_seen++;
	end
end

// Write responses are always accepted
always @(posedge aclk) begin
	if (aresetn && bvalid && bready !== 1'b1) begin
		$display("MISMATCH bready got=%h exp=1", bready);
		mismatch_errors++;
	end
end

always @(posedge aclk) begin
	ready_rnd <= lcg_next(ready_rnd);
	stat_tready <= ready_rnd[17];
end

task automatic wait_mac_ready();
	int t;
	t = 0;
	@(negedge aclk);
	while (!mac_tready) begin
		t++;
		if (t > 5000)
			raise_timeout("timeout waiting for mac_tready");
		@(negedge aclk);
	end
endtask

task automatic wait_reports(input int n);
	int t;
	t = 0;
	while (reports_done < n) begin
		t++;
		if (t > 5000)
			raise_timeout("timeout waiting for frame reports");
		@(negedge aclk);
	end
endtask

task automatic wait_level(input int val);
	int t;
	t = 0;
	while (ram_available != (`RX_ADDR_BITS+1)'(val)) begin
		t++;
		if (t > 2000)
			raise_timeout("timeout waiting for ram_available to recover");
		@(negedge aclk);
	end
endtask

task automatic return_space(input int len);
	int t;
	t = 0;
	@(posedge aclk);
	cmd_tdata <= {16'(len), 16'h0000};
	cmd_tvalid <= 1'b1;
	cmd_tlast <= 1'b1;
	@(negedge aclk);
	while (!cmd_tready) begin
		t++;
		if (t > 2000)
			raise_timeout("timeout waiting for cmd_tready");
		@(negedge aclk);
	end
	@(posedge aclk);
	cmd_tvalid <= 1'b0;
	cmd_tlast <= 1'b0;
	free_space += round_up(len);
endtask

// Frame must be held off, then freed space lets it in
task automatic make_room(input int len);
	wait_reports(frames_sent - 1);
	repeat (20) begin
		@(negedge aclk);
		if (mac_tready) begin
			$display("ERROR: mac_tready raised for a frame that does not fit");
			other_errors++;
		end
	end
	check_level(ram_available, free_space);
	while (free_space < round_up(len)) begin
		return_space(frame_len[ret_ptr]);
		ret_ptr++;
	end
endtask

task automatic send_frame(input int len, input logic [7:0] p, input bit blocked);
	int f;
	int nbeats;
	int k;
	logic [31:0] data;
	logic [3:0] keep;
	f = frames_sent;
	for (k = 0; k < len; k++) begin
		rnd = lcg_next(rnd);
		frame_data[f][k] = rnd[23:16];
	end
	frame_len[f] = len;
	frame_addr[f] = next_addr;
	frame_csum[f] = ref_checksum(f, int'(p));
	nbeats = round_up(len) / 4;
	frames_sent++;
	for (int bt = 0; bt < nbeats; bt++) begin
		data = 32'd0;
		keep = 4'd0;
		for (int j = 0; j < 4; j++) begin
			k = 4 * bt + j;
			rnd = lcg_next(rnd);
			if (k < len) begin
				data[31-8*j -: 8] = frame_data[f][k];
				keep[3-j] = 1'b1;
			end else begin
				data[31-8*j -: 8] = rnd[15:8];
			end
		end
		@(posedge aclk);
		mac_tdata <= data;
		mac_tkeep <= keep;
		mac_tuser <= 16'(len);
		mac_tlast <= (bt == nbeats - 1);
		mac_tvalid <= 1'b1;
		pcss <= p;
		if (bt == 0 && blocked)
			make_room(len);
		wait_mac_ready();
	end
	@(posedge aclk);
	mac_tvalid <= 1'b0;
	mac_tlast <= 1'b0;
	next_addr = (next_addr + round_up(len)) % BUF;
	free_space -= round_up(len);
endtask

task automatic send_random_frame(input bit may_block, output bit blocked);
	int len;
	logic [7:0] p;
	rnd = lcg_next(rnd);
	len = 1 + int'(rnd[25:16]);
	rnd = lcg_next(rnd);
	p = {3'd0, rnd[20:16]};
	blocked = may_block && (round_up(len) > free_space);
	send_frame(len, p, blocked);
endtask

initial begin
	bit blocked;
	aresetn = 1'b0;
	pcss = 8'd0;
	mac_tdata = 32'd0;
	mac_tkeep = 4'd0;
	mac_tuser = 16'd0;
	mac_tvalid = 1'b0;
	mac_tlast = 1'b0;
	cmd_tdata = 32'd0;
	cmd_tvalid = 1'b0;
	cmd_tlast = 1'b0;
	stat_tready = 1'b0;
	rnd = SEED;
	ready_rnd = SEED ^ 32'h5a5a0f0f;
	frames_sent = 0;
	reports_done = 0;
	aw_seen = 0;
	rpt_beat = 0;
	mismatch_errors = 0;
	other_errors = 0;
	next_addr = 0;
	free_space = BUF;
	ret_ptr = 0;
	blocked = 1'b0;
	repeat (8) @(posedge aclk);
	aresetn <= 1'b1;

	// Odd lengths, partial last beats, several start offsets
	send_frame(1, 8'd0, 1'b0);
	send_frame(2, 8'd1, 1'b0);
	send_frame(3, 8'd0, 1'b0);
	send_frame(7, 8'd3, 1'b0);
	send_frame(61, 8'd14, 1'b0);
	send_frame(64, 8'd2, 1'b0);
	send_frame(99, 8'd20, 1'b0);
	send_frame(1024, 8'd5, 1'b0);

	// Fill the buffer until a frame no longer fits
	while (!blocked && frames_sent < MAX_FRAMES - 16)
		send_random_frame(1'b1, blocked);
	if (!blocked) begin
		$display("ERROR: buffer never filled up");
		other_errors++;
	end

	wait_reports(frames_sent);
	while (ret_ptr < frames_sent) begin
		return_space(frame_len[ret_ptr]);
		ret_ptr++;
	end
	wait_level(free_space);
	check_level(ram_available, BUF);

	// Pointer is mid-buffer now, so some bursts wrap
	repeat (12)
		send_random_frame(1'b0, blocked);
	wait_reports(frames_sent);
	if (aw_seen != frames_sent) begin
		$display("ERROR: %0d AW bursts seen for %0d frames", aw_seen, frames_sent);
		other_errors++;
	end

	$display("frames=%0d mismatches=%0d other errors=%0d", frames_sent, mismatch_errors,
		other_errors);
	if (mismatch_errors == 0 && other_errors == 0)
		$display("TB PASSED");
	else
		$display("TB FAILED");
	$finish;
end

endmodule

// ==== test/tb_rx_mem.sv ====
`include "rx_consts.svh"

module tb_rx_mem import rx_pkg::*; #(
	parameter logic [31:0] SEED = 32'h1
) (
	input logic aclk,
	input logic aresetn,
	input axi_aw_t aw,
	input logic awvalid,
	output logic awready,
	input axi_w_t w,
	input logic wvalid,
	output logic wready,
	output axi_b_t b,
	output logic bvalid,
	input logic bready
);

logic [7:0] mem [`RX_BUF_BYTES];
logic [31:0] stall;
logic [`RX_ADDR_BITS-1:0] base;
logic [15:0] beat;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
	return s * 32'd1664525 + 32'd1013904223;
endfunction

// Random ready stalls, response one cycle after wlast
always @(posedge aclk or negedge aresetn) begin
	if (!aresetn) begin
		stall <= SEED;
		awready <= 1'b0;
		wready <= 1'b0;
		bvalid <= 1'b0;
		b <= '0;
	end else begin
		stall <= lcg_next(stall);
		awready <= stall[22:21] != 2'b00;
		wready <= stall[25:24] != 2'b00;
		if (bvalid && bready)
			bvalid <= 1'b0;
		if (wvalid && wready && w.last)
			bvalid <= 1'b1;
	end
end

// Buffer wraps modulo its size
always @(posedge aclk) begin
	if (awvalid && awready) begin
		base <= aw.addr;
		beat <= 16'd0;
	end
	if (wvalid && wready) begin
		for (int i = 0; i < 4; i++)
			if (w.strb[i])
				mem[(int'(base) + 4 * int'(beat) + i) % `RX_BUF_BYTES] <= w.data[8*i +: 8];
		beat <= beat + 16'd1;
	end
end

endmodule

// ==== verilog/rx_checksum.sv ====
module rx_checksum (
	input logic aclk,
	input logic aresetn,
	input logic [7:0] pcss,
	input logic [31:0] data,
	input logic [3:0] keep,
	input logic last,
	input logic beat_fire,
	output logic [15:0] csum,
	output logic csum_valid
);

// Byte offset of data[31:24] within the frame
logic [15:0] offset;
logic [15:0] sum;
logic [18:0] acc;
logic [16:0] fold;
logic [15:0] sum_next;

// Even offsets land in the high half of a big-endian word
function automatic logic [15:0] byte_term(
	input logic [7:0] value,
	input logic [15:0] off,
	input logic en,
	input logic [7:0] start
);
	logic [15:0] term;
	term = 16'd0;
	if (en && off >= {8'd0, start})
		term = off[0] ? {8'd0, value} : {value, 8'd0};
	return term;
endfunction

always_comb begin
	acc = {3'd0, sum};
	for (int i = 0; i < 4; i++)
		acc = acc + {3'd0, byte_term(data[31-8*i -: 8], offset + 16'(i), keep[3-i], pcss)};
	// End-around carry, two folds are enough
	fold = {1'b0, acc[15:0]} + {14'd0, acc[18:16]};
	sum_next = fold[15:0] + {15'd0, fold[16]};
end

always_ff @(posedge aclk or negedge aresetn) begin
	if (!aresetn) begin
		offset <= 16'd0;
		sum <= 16'd0;
		csum_valid <= 1'b0;
	end else begin
		csum_valid <= beat_fire && last;
		if (beat_fire) begin
			if (last) begin
				offset <= 16'd0;
				sum <= 16'd0;
			end else begin
				offset <= offset + 16'd4;
				sum <= sum_next;
			end
		end
	end
end

always_ff @(posedge aclk) begin
	if (beat_fire && last)
		csum <= sum_next;
end

endmodule

// ==== verilog/rx_frame.sv ====
`include "rx_consts.svh"

module rx_frame import rx_pkg::*; (
	input logic aclk,
	input logic aresetn,
	input logic [7:0] pcss,

	input logic [31:0] mac_tdata,
	input logic [3:0] mac_tkeep,
	input logic [15:0] mac_tuser,
	input logic mac_tvalid,
	input logic mac_tlast,
	output logic mac_tready,

	// Free-space returns, length in [31:16]
	input logic [31:0] cmd_tdata,
	input logic cmd_tvalid,
	input logic cmd_tlast,
	output logic cmd_tready,

	output rpt_word_u stat_tdata,
	output logic stat_tvalid,
	output logic stat_tlast,
	input logic stat_tready,

	output axi_aw_t aw,
	output logic awvalid,
	input logic awready,
	output axi_w_t w,
	output logic wvalid,
	input logic wready,
	input axi_b_t b,
	input logic bvalid,
	output logic bready,

	output logic [`RX_ADDR_BITS:0] ram_available
);

dma_cmd_t dma_cmd;
logic cmd_valid;
logic cmd_ready;
logic beat_fire;
logic done;
logic [15:0] csum;
logic csum_valid;

rx_wdma i_wdma (
	.aclk(aclk),
	.aresetn(aresetn),
	.dma_cmd(dma_cmd),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.mac_tdata(mac_tdata),
	.mac_tkeep(mac_tkeep),
	.mac_tvalid(mac_tvalid),
	.mac_tlast(mac_tlast),
	.mac_tready(mac_tready),
	.beat_fire(beat_fire),
	.aw(aw),
	.awvalid(awvalid),
	.awready(awready),
	.w(w),
	.wvalid(wvalid),
	.wready(wready),
	.b(b),
	.bvalid(bvalid),
	.bready(bready),
	.done(done),
	.bresp()
);

// Samples the same beats the DMA accepts
rx_checksum i_checksum (
	.aclk(aclk),
	.aresetn(aresetn),
	.pcss(pcss),
	.data(mac_tdata),
	.keep(mac_tkeep),
	.last(mac_tlast),
	.beat_fire(beat_fire),
	.csum(csum),
	.csum_valid(csum_valid)
);

rx_frame_ctrl i_frame_ctrl (
	.aclk(aclk),
	.aresetn(aresetn),
	.mac_tvalid(mac_tvalid),
	.mac_tuser(mac_tuser),
	.cmd_tdata(cmd_tdata),
	.cmd_tvalid(cmd_tvalid && cmd_tlast),
	.cmd_tready(cmd_tready),
	.dma_cmd(dma_cmd),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.done(done),
	.csum(csum),
	.csum_valid(csum_valid),
	.stat_tdata(stat_tdata),
	.stat_tvalid(stat_tvalid),
	.stat_tlast(stat_tlast),
	.stat_tready(stat_tready),
	.ram_available(ram_available)
);

endmodule

// ==== verilog/rx_frame_ctrl.sv ====
`include "rx_consts.svh"

module rx_frame_ctrl import rx_pkg::*; (
	input logic aclk,
	input logic aresetn,

	input logic mac_tvalid,
	input logic [15:0] mac_tuser,

	input logic [31:0] cmd_tdata,
	input logic cmd_tvalid,
	output logic cmd_tready,

	output dma_cmd_t dma_cmd,
	output logic cmd_valid,
	input logic cmd_ready,
	input logic done,

	input logic [15:0] csum,
	input logic csum_valid,

	output rpt_word_u stat_tdata,
	output logic stat_tvalid,
	output logic stat_tlast,
	input logic stat_tready,

	output logic [`RX_ADDR_BITS:0] ram_available
);

localparam logic [`RX_ADDR_BITS-1:0] ADDR_MASK = `RX_BUF_BYTES - 1;
localparam logic [`RX_ADDR_BITS:0] BUF_BYTES = `RX_BUF_BYTES;

typedef enum logic [2:0] {
	S_IDLE,
	S_CMD,
	S_WAIT,
	S_RPT0,
	S_RPT1,
	S_RPT2,
	S_COLLECT
} state_t;

state_t state, state_next;

logic [`RX_ADDR_BITS-1:0] wr_ptr;
logic [15:0] csum_reg;
logic done_seen;
logic csum_seen;
logic admit;
logic frame_end;
logic [15:0] mac_round;
logic [15:0] frame_round;
logic [15:0] fifo_round;

// Free-length FIFO, one entry per returned buffer
logic [15:0] fifo_mem [16];
logic [4:0] fifo_wp;
logic [4:0] fifo_rp;
logic fifo_full;
logic fifo_empty;
logic fifo_wr;
logic fifo_rd;

function automatic logic [15:0] round_len(input logic [15:0] len);
	return (len + 16'd3) & 16'hfffc;
endfunction

assign fifo_full = (fifo_wp[4] != fifo_rp[4]) && (fifo_wp[3:0] == fifo_rp[3:0]);
assign fifo_empty = (fifo_wp == fifo_rp);
assign cmd_tready = !fifo_full;
assign fifo_wr = cmd_tvalid && cmd_tready;
assign fifo_rd = (state == S_COLLECT);

assign mac_round = round_len(mac_tuser);
assign frame_round = round_len(dma_cmd.bytes);
assign fifo_round = round_len(fifo_mem[fifo_rp[3:0]]);

assign admit = mac_tvalid && ({1'b0, mac_round} <= ram_available);
assign frame_end = (done_seen || done) && (csum_seen || csum_valid);

assign cmd_valid = (state == S_CMD);
assign stat_tvalid = (state == S_RPT0) || (state == S_RPT1) || (state == S_RPT2);
assign stat_tlast = (state == S_RPT2);

always_comb begin
	stat_tdata = '0;
	case (state)
		S_RPT0: begin
			stat_tdata.place.len = dma_cmd.bytes;
			stat_tdata.place.addr = dma_cmd.addr;
		end
		S_RPT1: begin
			stat_tdata.csum.csum = csum_reg;
			stat_tdata.csum.len = dma_cmd.bytes;
		end
		S_RPT2: begin
			stat_tdata.desc.ixsm = 1'b1;
		end
		default: begin
			stat_tdata = '0;
		end
	endcase
end

always_comb begin
	state_next = state;
	case (state)
		S_IDLE: begin
			if (admit)
				state_next = S_CMD;
			else if (!fifo_empty)
				state_next = S_COLLECT;
		end
		S_CMD: if (cmd_ready) state_next = S_WAIT;
		S_WAIT: if (frame_end) state_next = S_RPT0;
		S_RPT0: if (stat_tready) state_next = S_RPT1;
		S_RPT1: if (stat_tready) state_next = S_RPT2;
		S_RPT2: if (stat_tready) state_next = S_IDLE;
		default: state_next = S_IDLE;
	endcase
end

always_ff @(posedge aclk or negedge aresetn) begin
	if (!aresetn) begin
		state <= S_IDLE;
		wr_ptr <= '0;
		ram_available <= BUF_BYTES;
		done_seen <= 1'b0;
		csum_seen <= 1'b0;
	end else begin
		state <= state_next;
		if (state == S_IDLE && admit) begin
			done_seen <= 1'b0;
			csum_seen <= 1'b0;
		end else begin
			if (done)
				done_seen <= 1'b1;
			if (csum_valid)
				csum_seen <= 1'b1;
		end
		// Space is committed once the frame is in memory
		if (state == S_WAIT && frame_end) begin
			wr_ptr <= (wr_ptr + frame_round) & ADDR_MASK;
			ram_available <= ram_available - {1'b0, frame_round};
		end else if (state == S_COLLECT) begin
			ram_available <= ram_available + {1'b0, fifo_round};
		end
	end
end

always_ff @(posedge aclk) begin
	if (state == S_IDLE && admit) begin
		dma_cmd.addr <= wr_ptr;
		dma_cmd.bytes <= mac_tuser;
	end
	if (csum_valid)
		csum_reg <= csum;
	if (fifo_wr)
		fifo_mem[fifo_wp[3:0]] <= cmd_tdata[31:16];
end

always_ff @(posedge aclk or negedge aresetn) begin
	if (!aresetn) begin
		fifo_wp <= 5'd0;
		fifo_rp <= 5'd0;
	end else begin
		if (fifo_wr)
			fifo_wp <= fifo_wp + 5'd1;
		if (fifo_rd)
			fifo_rp <= fifo_rp + 5'd1;
	end
end

endmodule
